/* build.f */
+incdir+.
flush_pkg.sv
up_down_counter.sv
flush_ctrl.sv
fence_t_seq.sv
dcache_flush_unit.sv
flush_subsys_top.sv
tb_flush_subsys.sv

/* dcache_flush_unit.sv */
// Write-back data cache dirty bitmap with store port and ordered write-back on flush
`default_nettype none

module dcache_flush_unit (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Store port
  input  logic                             store_valid_i,
  input  logic [flush_pkg::LINE_IDX_W-1:0] store_idx_i,
  output logic                             store_ready_o,
  // Flush request from the controller
  input  logic                             flush_i,       // Level, held until ack
  input  logic                             stall_i,       // fence.t in progress
  output logic                             flush_ack_o,   // One cycle
  output logic                             busy_o,
  // Memory write-back port
  output logic                             wb_valid_o,
  output logic [flush_pkg::LINE_IDX_W-1:0] wb_idx_o,
  input  logic                             wb_ready_i
);

  logic [flush_pkg::CACHE_LINES-1:0] dirty_d, dirty_q;
  logic                              any_dirty;
  logic                              ack_q;

  assign any_dirty = |dirty_q;

  // No new stores while flushing, keeps the write-back index stable
  assign store_ready_o = ~stall_i & ~flush_i;

  // Lowest dirty line goes out first
  always_comb begin
    wb_idx_o = '0;
    for (int i = flush_pkg::CACHE_LINES - 1; i >= 0; i--) begin
      if (dirty_q[i]) wb_idx_o = i[flush_pkg::LINE_IDX_W-1:0];
    end
  end

  assign wb_valid_o  = flush_i & any_dirty;
  assign busy_o      = wb_valid_o;  // Write-back outstanding
  assign flush_ack_o = ack_q;

  // ----------------------------------------
  // Dirty bitmap
  // ----------------------------------------
  always_comb begin
    dirty_d = dirty_q;
    if (wb_valid_o && wb_ready_i) dirty_d[wb_idx_o] = 1'b0;             // Line written back
    if (store_valid_i && store_ready_o) dirty_d[store_idx_i] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dirty_q <= '0;
      ack_q   <= 1'b0;
    end else begin
      dirty_q <= dirty_d;
      ack_q   <= flush_i & ~any_dirty & ~ack_q;  // Single pulse per request
    end
  end

  a_wb_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_idx_o));

endmodule

`default_nettype wire

/* fence_t_seq.sv */
// fence.t microreset sequencer with drain and pad counters, reset address and cache init stretch
`default_nettype none

module fence_t_seq (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fence_t_i,
  input  logic                        flush_ack_i,
  input  logic                        cache_busy_i,
  input  logic [flush_pkg::PAD_W-1:0] fence_t_pad_i,      // Pad cycles after the source event
  input  logic                        fence_t_src_sel_i,  // 0 timer edge, 1 leaving U-mode
  input  logic                        time_irq_i,
  input  flush_pkg::priv_lvl_e        priv_lvl_i,
  input  logic [flush_pkg::VLEN-1:0]  boot_addr_i,
  input  logic [flush_pkg::VLEN-1:0]  pc_commit_i,
  output logic                        busy_o,
  output logic                        rst_uarch_no,
  output logic                        cache_init_no,
  output logic [flush_pkg::PAD_W-1:0] fence_t_ceil_o,
  output logic [flush_pkg::VLEN-1:0]  rst_addr_o
);

  flush_pkg::fence_t_state_e state_d, state_q;

  logic [flush_pkg::RST_CNT_W-1:0]         rst_cnt_d, rst_cnt_q;      // Microreset length
  logic [flush_pkg::CACHE_INIT_CYCLES-1:0] cache_init_d, cache_init_q;
  logic [flush_pkg::DRAIN_W-1:0]           drain_cnt;
  logic [flush_pkg::PAD_W-1:0]             pad_cnt;
  logic [flush_pkg::VLEN-1:0]              rst_addr_q;
  logic                                    time_irq_q;
  flush_pkg::priv_lvl_e                    priv_lvl_q;
  logic                                    load_pad, drain_done, rst_last;

  assign busy_o        = (state_q != flush_pkg::FT_IDLE);  // Halt and cache stall
  assign rst_uarch_no  = (state_q != flush_pkg::FT_RST_UARCH);
  assign cache_init_no = |cache_init_q;
  assign rst_addr_o    = rst_addr_q;

  assign drain_done = (drain_cnt == flush_pkg::DRAIN_W'(flush_pkg::DRAIN_IDLE_CYCLES));
  assign rst_last   = (rst_cnt_q == flush_pkg::RST_CNT_W'(flush_pkg::RST_UARCH_CYCLES - 1));

  // Pad starts on a timer rising edge or on leaving U-mode
  assign load_pad = fence_t_src_sel_i ?
                    (priv_lvl_q == flush_pkg::PRIV_U) && (priv_lvl_i != flush_pkg::PRIV_U) :
                    time_irq_i & ~time_irq_q;

  // ----------------------------------------
  // Counters
  // ----------------------------------------
  up_down_counter #(.WIDTH(flush_pkg::DRAIN_W)) u_drain_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (cache_busy_i | (state_q != flush_pkg::FT_DRAIN)),  // Restart on any activity
    .en_i    (~drain_done),                                      // Saturate
    .load_i  (1'b0),
    .down_i  (1'b0),
    .d_i     ('0),
    .q_o     (drain_cnt)
  );

  up_down_counter #(.WIDTH(flush_pkg::PAD_W)) u_pad_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (1'b0),
    .en_i    (|pad_cnt),      // Down to zero then stop
    .load_i  (load_pad),
    .down_i  (1'b1),
    .d_i     (fence_t_pad_i),
    .q_o     (pad_cnt)
  );

  // ----------------------------------------
  // Sequencer FSM
  // ----------------------------------------
  always_comb begin
    state_d        = state_q;
    rst_cnt_d      = '0;
    fence_t_ceil_o = '0;
    cache_init_d   = {cache_init_q[flush_pkg::CACHE_INIT_CYCLES-2:0], 1'b0};

    unique case (state_q)
      flush_pkg::FT_IDLE: begin
        if (fence_t_i) state_d = flush_pkg::FT_FLUSH_DCACHE;
      end
      flush_pkg::FT_FLUSH_DCACHE: begin
        if (flush_ack_i) state_d = flush_pkg::FT_DRAIN;  // Dirty lines are out
      end
      flush_pkg::FT_DRAIN: begin
        if (drain_done) begin
          state_d        = flush_pkg::FT_PAD;
          // Report how far the pad had already run
          fence_t_ceil_o = (pad_cnt == '0) ? '0 : fence_t_pad_i - pad_cnt;
        end
      end
      flush_pkg::FT_PAD: begin
        if (pad_cnt == '0) state_d = flush_pkg::FT_RST_UARCH;
      end
      flush_pkg::FT_RST_UARCH: begin
        rst_cnt_d = rst_cnt_q + 1'b1;
        if (rst_last) begin
          state_d         = flush_pkg::FT_IDLE;
          cache_init_d[0] = 1'b1;  // Suppress cache init once reset lifts
        end
      end
      default: state_d = flush_pkg::FT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= flush_pkg::FT_IDLE;
      rst_cnt_q    <= '0;
      cache_init_q <= '0;
      rst_addr_q   <= boot_addr_i;
      time_irq_q   <= 1'b0;
      priv_lvl_q   <= flush_pkg::PRIV_M;
    end else begin
      state_q      <= state_d;
      rst_cnt_q    <= rst_cnt_d;
      cache_init_q <= cache_init_d;
      time_irq_q   <= time_irq_i;  // Edge detect
      priv_lvl_q   <= priv_lvl_i;
      // Resume after the fence.t instruction
      if (fence_t_i) begin
        rst_addr_q <= pc_commit_i + {{(flush_pkg::VLEN - 3){1'b0}}, 3'b100};
      end
    end
  end

  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {flush_pkg::FT_IDLE, flush_pkg::FT_FLUSH_DCACHE, flush_pkg::FT_DRAIN,
                    flush_pkg::FT_PAD, flush_pkg::FT_RST_UARCH});

endmodule

`default_nettype wire

/* flush_ctrl.sv */
// Flush controller decoding pipeline events and fence opcodes into stage flushes and halt
`default_nettype none

module flush_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Pipeline events, single-cycle pulses
  input  logic                 mispredict_i,
  input  logic                 ex_valid_i,
  input  logic                 eret_i,
  input  logic                 flush_csr_i,
  input  flush_pkg::fence_op_e fence_op_i,
  // Data cache flush handshake
  input  logic                 flush_ack_i,
  input  logic                 fence_t_busy_i,  // fence.t sequence running
  // Stage flushes
  output logic                 set_pc_commit_o,
  output logic                 flush_if_o,
  output logic                 flush_unissued_o,
  output logic                 flush_id_o,
  output logic                 flush_ex_o,
  output logic                 flush_bp_o,
  output logic                 flush_icache_o,
  output logic                 flush_tlb_o,
  output logic                 flush_dcache_o,
  output logic                 halt_o,
  output logic                 fence_t_o  // Decoded fence.t for the sequencer
);

  logic fence_active_d, fence_active_q;  // Data cache flush in flight
  logic is_fence, is_fence_i, is_sfence;
  logic dcache_start;                    // Opcode that needs a write-back

  // Opcode decode, done once here
  assign is_fence     = (fence_op_i == flush_pkg::FENCE);
  assign is_fence_i   = (fence_op_i == flush_pkg::FENCE_I);
  assign is_sfence    = (fence_op_i == flush_pkg::SFENCE_VMA);
  assign fence_t_o    = (fence_op_i == flush_pkg::FENCE_T);
  assign dcache_start = is_fence | is_fence_i | fence_t_o;

  // ----------------------------------------
  // Stage flush decode
  // ----------------------------------------
  always_comb begin
    set_pc_commit_o  = 1'b0;
    flush_if_o       = 1'b0;
    flush_unissued_o = 1'b0;
    flush_id_o       = 1'b0;
    flush_ex_o       = 1'b0;
    flush_bp_o       = 1'b0;
    flush_icache_o   = 1'b0;
    flush_tlb_o      = 1'b0;

    // Wrong path fetched, drop front end only
    if (mispredict_i) begin
      flush_if_o       = 1'b1;
      flush_unissued_o = 1'b1;
    end

    // Fences and CSR side effects restart from the commit PC
    if (is_fence || is_fence_i || is_sfence || flush_csr_i) begin
      set_pc_commit_o  = 1'b1;
      flush_if_o       = 1'b1;
      flush_unissued_o = 1'b1;
      flush_id_o       = 1'b1;
      flush_ex_o       = 1'b1;
    end

    if (is_fence_i) flush_icache_o = 1'b1;  // Stale instructions
    if (is_sfence)  flush_tlb_o    = 1'b1;  // Stale translations
    if (fence_t_o)  flush_icache_o = 1'b1;  // Rest is up to the sequencer

    // Trap entry or return, PC comes from the trap logic
    if (ex_valid_i || eret_i) begin
      set_pc_commit_o  = 1'b0;
      flush_if_o       = 1'b1;
      flush_unissued_o = 1'b1;
      flush_id_o       = 1'b1;
      flush_ex_o       = 1'b1;
      flush_bp_o       = 1'b1;  // No speculative fetch across privilege change
    end
  end

  // ----------------------------------------
  // Data cache flush tracking
  // ----------------------------------------
  always_comb begin
    fence_active_d = fence_active_q;
    if (fence_active_q && flush_ack_i) begin
      fence_active_d = 1'b0;  // Write-back done
    end
    if (dcache_start) begin
      fence_active_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_active_q <= 1'b0;
    end else begin
      fence_active_q <= fence_active_d;
    end
  end

  assign flush_dcache_o = fence_active_q;  // Level request, held until ack

  // Core waits for the write-back or the whole fence.t sequence
  assign halt_o = fence_active_q | fence_t_busy_i;

  // Cache only answers a request that this block raised
  a_ack_has_fence : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_ack_i |-> fence_active_q);

endmodule

`default_nettype wire

/* flush_pkg.sv */
// Flush subsystem package with sizing constants and the opcode, privilege and fence.t state enums
`default_nettype none

package flush_pkg;

  // ----------------------------------------
  // Sizing
  // ----------------------------------------
  localparam int unsigned VLEN              = 32;  // Address width
  localparam int unsigned CACHE_LINES       = 16;  // Lines in the data cache
  localparam int unsigned LINE_IDX_W        = 4;   // Line index width
  localparam int unsigned DRAIN_IDLE_CYCLES = 15;  // Saturation value of the drain count
  localparam int unsigned RST_UARCH_CYCLES  = 16;  // Length of the microreset
  localparam int unsigned CACHE_INIT_CYCLES = 3;   // Cache init suppression after microreset
  localparam int unsigned PAD_W             = 32;  // Pad counter width

  // Derived counter widths
  localparam int unsigned DRAIN_W   = $clog2(DRAIN_IDLE_CYCLES + 1);
  localparam int unsigned RST_CNT_W = $clog2(RST_UARCH_CYCLES);

  // ----------------------------------------
  // Fence opcodes from decode
  // ----------------------------------------
  typedef enum logic [2:0] {
    FENCE_NONE = 3'd0,  // No fence this cycle
    FENCE      = 3'd1,  // Memory ordering, flushes the data cache
    FENCE_I    = 3'd2,  // Instruction stream sync
    SFENCE_VMA = 3'd3,  // Address translation sync
    FENCE_T    = 3'd4   // Timing channel microreset
  } fence_op_e;

  // Privilege levels, RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // ----------------------------------------
  // fence.t sequencer states
  // ----------------------------------------
  typedef enum logic [2:0] {
    FT_IDLE,          // Waiting for fence.t
    FT_FLUSH_DCACHE,  // Waiting for the write-back acknowledge
    FT_DRAIN,         // Cache must stay idle for the drain window
    FT_PAD,           // Waiting for the pad count to run out
    FT_RST_UARCH      // Microarchitecture held in reset
  } fence_t_state_e;

endpackage

`default_nettype wire

/* flush_subsys_top.sv */
// Flush subsystem top wiring the controller, the fence.t sequencer and the cache flush unit
`default_nettype none

module flush_subsys_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Pipeline events
  input  logic                             mispredict_i,
  input  logic                             ex_valid_i,
  input  logic                             eret_i,
  input  logic                             flush_csr_i,
  input  flush_pkg::fence_op_e             fence_op_i,
  // Stage flushes and halt
  output logic                             set_pc_commit_o,
  output logic                             flush_if_o,
  output logic                             flush_unissued_o,
  output logic                             flush_id_o,
  output logic                             flush_ex_o,
  output logic                             flush_bp_o,
  output logic                             flush_icache_o,
  output logic                             flush_tlb_o,
  output logic                             halt_o,
  // fence.t control
  input  logic [flush_pkg::PAD_W-1:0]      fence_t_pad_i,
  input  logic                             fence_t_src_sel_i,
  input  logic                             time_irq_i,
  input  flush_pkg::priv_lvl_e             priv_lvl_i,
  input  logic [flush_pkg::VLEN-1:0]       boot_addr_i,
  input  logic [flush_pkg::VLEN-1:0]       pc_commit_i,
  output logic                             rst_uarch_no,
  output logic                             cache_init_no,
  output logic [flush_pkg::PAD_W-1:0]      fence_t_ceil_o,
  output logic [flush_pkg::VLEN-1:0]       rst_addr_o,
  // Store port
  input  logic                             store_valid_i,
  input  logic [flush_pkg::LINE_IDX_W-1:0] store_idx_i,
  output logic                             store_ready_o,
  // Memory write-back port
  output logic                             wb_valid_o,
  output logic [flush_pkg::LINE_IDX_W-1:0] wb_idx_o,
  input  logic                             wb_ready_i
);

  logic flush_dcache, flush_ack, cache_busy;
  logic fence_t, stall_cache;  // stall_cache also holds the halt

  flush_ctrl u_flush_ctrl (
    .clk_i, .rst_ni,
    .mispredict_i, .ex_valid_i, .eret_i, .flush_csr_i, .fence_op_i,
    .flush_ack_i      (flush_ack),
    .fence_t_busy_i   (stall_cache),
    .set_pc_commit_o, .flush_if_o, .flush_unissued_o, .flush_id_o, .flush_ex_o,
    .flush_bp_o, .flush_icache_o, .flush_tlb_o,
    .flush_dcache_o   (flush_dcache),
    .halt_o,
    .fence_t_o        (fence_t)
  );

  fence_t_seq u_fence_t_seq (
    .clk_i, .rst_ni,
    .fence_t_i        (fence_t),
    .flush_ack_i      (flush_ack),
    .cache_busy_i     (cache_busy),
    .fence_t_pad_i, .fence_t_src_sel_i, .time_irq_i, .priv_lvl_i,
    .boot_addr_i, .pc_commit_i,
    .busy_o           (stall_cache),
    .rst_uarch_no, .cache_init_no, .fence_t_ceil_o, .rst_addr_o
  );

  dcache_flush_unit u_dcache_flush_unit (
    .clk_i, .rst_ni,
    .store_valid_i, .store_idx_i, .store_ready_o,
    .flush_i          (flush_dcache),
    .stall_i          (stall_cache),
    .flush_ack_o      (flush_ack),
    .busy_o           (cache_busy),
    .wb_valid_o, .wb_idx_o, .wb_ready_i
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run the flush subsystem testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_flush_subsys -f build.f -o sim_flush

./obj_dir/sim_flush | tee sim.log

# A crash leaves no closing line, so the pass line must be present too
if grep -q "Done: errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "Simulation FAILED, run ended early"
  exit 1
fi
echo "Simulation PASSED"

/* tb_flush_tests.svh */
// Directed test tasks for the flush subsystem, stage flush and write-back log checks
`ifndef TB_FLUSH_TESTS_SVH
`define TB_FLUSH_TESTS_SVH

  // Bit order is set_pc, if, unissued, id, ex, bp, icache, tlb
  task automatic check_stage_flushes(input string name, input logic [7:0] exp);
    check_bit({name, " set_pc_commit"}, exp[7], set_pc_commit_o);
    check_bit({name, " flush_if"}, exp[6], flush_if_o);
    check_bit({name, " flush_unissued"}, exp[5], flush_unissued_o);
    check_bit({name, " flush_id"}, exp[4], flush_id_o);
    check_bit({name, " flush_ex"}, exp[3], flush_ex_o);
    check_bit({name, " flush_bp"}, exp[2], flush_bp_o);
    check_bit({name, " flush_icache"}, exp[1], flush_icache_o);
    check_bit({name, " flush_tlb"}, exp[0], flush_tlb_o);
  endtask

  function automatic logic in_drain();
    return u_flush_subsys_top.u_fence_t_seq.state_q == flush_pkg::FT_DRAIN;
  endfunction

  task automatic store_line(input logic [flush_pkg::LINE_IDX_W-1:0] idx);
    @(posedge clk_i);
    store_valid_i    <= 1'b1;
    store_idx_i      <= idx;
    dirty_model[idx] = 1'b1;
    @(posedge clk_i);
    store_valid_i <= 1'b0;  // Ready is high while idle, one beat taken
  endtask

  // Dirty lines must come back once each, lowest index first
  task automatic check_wb_log(input string name);
    for (int i = 0; i < flush_pkg::CACHE_LINES; i++) begin
      if (dirty_model[i] && wb_log.size() == 0) begin
        other_errs++;
        $display("Test %s never saw line %0d written back", name, i);
      end else if (dirty_model[i]) begin
        check_idx({name, " wb order"}, flush_pkg::LINE_IDX_W'(i), wb_log.pop_front());
      end
    end
    if (wb_log.size() != 0) begin
      other_errs++;
      $display("Test %s saw %0d write-back beats too many", name, wb_log.size());
    end
    dirty_model = '0;
    wb_log.delete();
  endtask

  task automatic test_event_flushes();
    @(posedge clk_i);
    mispredict_i <= 1'b1;
    @(negedge clk_i);
    check_stage_flushes("mispredict", 8'b0110_0000);  // Front end only
    @(posedge clk_i);
    mispredict_i <= 1'b0;
    ex_valid_i   <= 1'b1;
    @(negedge clk_i);
    check_stage_flushes("exception", 8'b0111_1100);
    @(posedge clk_i);
    ex_valid_i <= 1'b0;
    eret_i     <= 1'b1;
    @(negedge clk_i);
    check_stage_flushes("eret", 8'b0111_1100);
    @(posedge clk_i);
    eret_i      <= 1'b0;
    flush_csr_i <= 1'b1;
    @(negedge clk_i);
    check_stage_flushes("csr", 8'b1111_1000);  // Restart from commit PC
    @(posedge clk_i);
    flush_csr_i <= 1'b0;
  endtask

  task automatic run_fence(input string name, input flush_pkg::fence_op_e op,
                           input logic [7:0] exp_flushes);
    int unsigned n;
    @(posedge clk_i);
    fence_op_i <= op;
    @(negedge clk_i);
    check_stage_flushes(name, exp_flushes);
    @(posedge clk_i);
    fence_op_i <= flush_pkg::FENCE_NONE;
    // Halt covers the write-back and the acknowledge cycle
    for (n = 0; n < 100; n++) begin
      @(negedge clk_i);
      check_bit({name, " halt"}, 1'b1, halt_o);
      if (u_flush_subsys_top.flush_ack) break;
    end
    if (n == 100) report_timeout(name, "flush acknowledge");
    @(negedge clk_i);
    check_bit({name, " halt after ack"}, 1'b0, halt_o);
    check_wb_log(name);
  endtask

  task automatic test_fence_stores();
    store_line(4'd9);
    store_line(4'd2);
    store_line(4'd5);
    run_fence("fence", flush_pkg::FENCE, 8'b1111_1000);
  endtask

  task automatic test_fence_i();
    run_fence("fence_i clean", flush_pkg::FENCE_I, 8'b1111_1010);
    store_line(4'd15);
    store_line(4'd0);
    store_line(4'd7);
    run_fence("fence_i dirty", flush_pkg::FENCE_I, 8'b1111_1010);
  endtask

  task automatic test_sfence_vma();
    @(posedge clk_i);
    fence_op_i <= flush_pkg::SFENCE_VMA;
    @(negedge clk_i);
    check_stage_flushes("sfence_vma", 8'b1111_1001);
    @(posedge clk_i);
    fence_op_i <= flush_pkg::FENCE_NONE;
    repeat (4) begin
      @(negedge clk_i);
      check_bit("sfence_vma halt", 1'b0, halt_o);
      check_bit("sfence_vma flush_dcache", 1'b0, u_flush_subsys_top.flush_dcache);
    end
  endtask

  // ----------------------------------------
  // fence.t microreset sequence
  // ----------------------------------------
  task automatic test_fence_t(input string name, input logic src_sel,
                              input logic [flush_pkg::PAD_W-1:0] pad,
                              input logic [flush_pkg::VLEN-1:0] pc);
    int unsigned n;
    int unsigned elapsed;
    int unsigned last_elapsed;
    logic [flush_pkg::PAD_W-1:0] last_ceil;
    logic [flush_pkg::PAD_W-1:0] exp_ceil;
    @(posedge clk_i);
    fence_t_src_sel_i <= src_sel;
    fence_t_pad_i     <= pad;
    pc_commit_i       <= pc;
    priv_lvl_i        <= flush_pkg::PRIV_U;
    store_line(4'd3);
    @(posedge clk_i);
    fence_op_i <= flush_pkg::FENCE_T;
    @(negedge clk_i);
    check_stage_flushes(name, 8'b0000_0010);  // Only the icache directly
    @(posedge clk_i);
    fence_op_i <= flush_pkg::FENCE_NONE;
    @(negedge clk_i);
    check_addr({name, " rst_addr"}, pc + 32'd4, rst_addr_o);
    for (n = 0; n < 100 && !in_drain(); n++) begin
      check_bit({name, " store_ready"}, 1'b0, store_ready_o);
      check_bit({name, " halt"}, 1'b1, halt_o);
      @(negedge clk_i);
    end
    if (n == 100) report_timeout(name, "drain state");
    @(posedge clk_i);
    if (src_sel) priv_lvl_i <= flush_pkg::PRIV_S;  // Leave U-mode
    else time_irq_i <= 1'b1;                         // Timer edge
    @(posedge clk_i);  // Pad count holds the setting from this edge
    last_ceil    = '0;
    last_elapsed = 0;
    for (elapsed = 0; elapsed < 100; elapsed++) begin
      @(negedge clk_i);
      if (!in_drain()) break;
      check_bit({name, " store_ready"}, 1'b0, store_ready_o);
      check_bit({name, " halt"}, 1'b1, halt_o);
      last_ceil    = fence_t_ceil_o;  // Last drain cycle holds the pulse
      last_elapsed = elapsed;
    end
    if (elapsed == 100) report_timeout(name, "end of the drain");
    // Drain exits DRAIN_IDLE_CYCLES after entry, the pad was loaded two cycles in
    check_cycles({name, " pad cycles at drain exit"}, flush_pkg::DRAIN_IDLE_CYCLES - 2,
                 last_elapsed);
    // Pad cycles already run, zero once the pad has expired
    exp_ceil = (pad > flush_pkg::DRAIN_IDLE_CYCLES - 2) ?
               flush_pkg::PAD_W'(flush_pkg::DRAIN_IDLE_CYCLES - 2) : '0;
    check_pad({name, " ceil"}, exp_ceil, last_ceil);
    for (n = 0; n < 100 && rst_uarch_no; n++) begin
      check_bit({name, " store_ready"}, 1'b0, store_ready_o);
      check_bit({name, " halt"}, 1'b1, halt_o);
      @(negedge clk_i);
    end
    if (n == 100) report_timeout(name, "microreset");
    for (n = 0; n < 40 && !rst_uarch_no; n++) @(negedge clk_i);
    check_cycles({name, " rst_uarch low"}, flush_pkg::RST_UARCH_CYCLES, n);
    for (n = 0; n < 10 && cache_init_no; n++) @(negedge clk_i);
    check_cycles({name, " cache_init high"}, flush_pkg::CACHE_INIT_CYCLES, n);
    check_bit({name, " halt after sequence"}, 1'b0, halt_o);
    check_wb_log(name);
    @(posedge clk_i);
    time_irq_i <= 1'b0;
    priv_lvl_i <= flush_pkg::PRIV_M;
  endtask

`endif

/* tb_flush_subsys.sv */
// Testbench top with clock, reset, DUT, memory sink, compare tasks and watchdog
`default_nettype none

module tb_flush_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned PAD_LONG  = 40;  // Outlasts the drain window
  localparam int unsigned PAD_SHORT = 3;   // Runs out inside the drain window
  // Reset, events, three flushes, sfence, then two fence.t runs with their pads
  localparam int unsigned WATCHDOG_CYCLES = 8 + 20 + 60 + 80 + 20
                                            + 2 * 100 + PAD_LONG + PAD_SHORT + 200;

  logic clk_i, rst_ni;
  logic mispredict_i, ex_valid_i, eret_i, flush_csr_i;
  flush_pkg::fence_op_e fence_op_i;
  logic set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o, flush_ex_o;
  logic flush_bp_o, flush_icache_o, flush_tlb_o, halt_o;
  logic [flush_pkg::PAD_W-1:0] fence_t_pad_i, fence_t_ceil_o;
  logic fence_t_src_sel_i, time_irq_i, rst_uarch_no, cache_init_no;
  flush_pkg::priv_lvl_e priv_lvl_i;
  logic [flush_pkg::VLEN-1:0] boot_addr_i, pc_commit_i, rst_addr_o;
  logic store_valid_i, store_ready_o, wb_valid_o;
  logic [flush_pkg::LINE_IDX_W-1:0] store_idx_i, wb_idx_o;
  logic wb_ready_i = 1'b0;  // Memory sink drives it after time zero

  logic [flush_pkg::LINE_IDX_W-1:0] wb_log[$];     // Indices accepted by memory
  logic [flush_pkg::CACHE_LINES-1:0] dirty_model;  // Lines stored since the last flush
  int unsigned value_errs, other_errs;

  flush_subsys_top u_flush_subsys_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  // ----------------------------------------
  // Memory sink with random back-pressure
  // ----------------------------------------
  initial begin
    void'($urandom(4));
    forever begin
      @(posedge clk_i);
      if (wb_valid_o && wb_ready_i) wb_log.push_back(wb_idx_o);  // Beat taken
      wb_ready_i <= ($urandom % 4) != 0;  // Ready about three cycles in four
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("ERROR %s: expected %0b, got %0b", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [flush_pkg::VLEN-1:0] exp,
                            input logic [flush_pkg::VLEN-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("ERROR %s: expected %08h, got %08h", name, exp, act);
    end
  endtask

  task automatic check_idx(input string name, input logic [flush_pkg::LINE_IDX_W-1:0] exp,
                           input logic [flush_pkg::LINE_IDX_W-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("ERROR %s: expected line %0d, got line %0d", name, exp, act);
    end
  endtask

  task automatic check_pad(input string name, input logic [flush_pkg::PAD_W-1:0] exp,
                           input logic [flush_pkg::PAD_W-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("ERROR %s: expected %0d, got %0d", name, exp, act);
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      value_errs++;
      $display("ERROR %s: expected %0d cycles, got %0d cycles", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    other_errs++;
    $display("Test %s gave up waiting for the %s", name, what);
  endtask

  `include "tb_flush_tests.svh"

  initial begin
    rst_ni            = 1'b0;
    mispredict_i      = 1'b0;
    ex_valid_i        = 1'b0;
    eret_i            = 1'b0;
    flush_csr_i       = 1'b0;
    fence_op_i        = flush_pkg::FENCE_NONE;
    fence_t_pad_i     = '0;
    fence_t_src_sel_i = 1'b0;
    time_irq_i        = 1'b0;
    priv_lvl_i        = flush_pkg::PRIV_M;
    boot_addr_i       = 32'h0001_0000;
    pc_commit_i       = '0;
    store_valid_i     = 1'b0;
    store_idx_i       = '0;
    dirty_model       = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    // Quiet state out of reset
    check_stage_flushes("reset", 8'h00);
    check_bit("reset halt", 1'b0, halt_o);
    check_bit("reset wb_valid", 1'b0, wb_valid_o);
    check_bit("reset rst_uarch_n", 1'b1, rst_uarch_no);
    check_bit("reset cache_init_n", 1'b0, cache_init_no);
    check_addr("reset rst_addr", boot_addr_i, rst_addr_o);

    test_event_flushes();
    test_fence_stores();
    test_fence_i();
    test_sfence_vma();
    test_fence_t("fence_t timer", 1'b0, PAD_LONG, 32'h8000_0100);
    test_fence_t("fence_t priv", 1'b1, PAD_SHORT, 32'h8000_2ffc);

    $display("Checks finished with %0d value errors and %0d other errors",
             value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* up_down_counter.sv */
// Loadable, clearable up/down counter with enable and wrap-around
`default_nettype none

module up_down_counter #(
  parameter int unsigned WIDTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,  // Back to zero, wins over everything
  input  logic             en_i,     // Count this cycle
  input  logic             load_i,   // Take d_i, wins over counting
  input  logic             down_i,   // Count direction
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  logic [WIDTH-1:0] cnt_q;

  assign q_o = cnt_q;

  // ----------------------------------------
  // Count register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= d_i;
    end else if (en_i) begin
      // Wraps in both directions
      cnt_q <= down_i ? cnt_q - WIDTH'(1) : cnt_q + WIDTH'(1);
    end
  end

  // Count must be known once out of reset, the sequencer decodes it
  a_q_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(q_o));

endmodule

`default_nettype wire
